// File: src/imu_pkg.sv
`default_nettype none

// ==================================================
// IMU packet format shared by receivers and store
// ==================================================
package imu_pkg;

    // Byte 0 of every packet
    localparam logic [7:0] HEADER_BYTE = 8'hAA;

    // Header, seven 16-bit words, flag byte
    localparam int PACKET_BYTES = 16;

    // Bit positions inside the flag byte (byte 15)
    localparam int FLAG_QUAT_BIT = 0;
    localparam int FLAG_GYRO_BIT = 1;

    // Decoded packet, 114 bits
    // Words arrive MSB byte first on the wire
    typedef struct packed {
        logic signed [15:0] quat_w;
        logic signed [15:0] quat_x;
        logic signed [15:0] quat_y;
        logic signed [15:0] quat_z;
        logic signed [15:0] gyro_x;
        logic signed [15:0] gyro_y;
        logic signed [15:0] gyro_z;
        logic               quat_valid;
        logic               gyro_valid;
    } imu_rec_t;

endpackage

`default_nettype wire

// File: src/hub_pkg.sv
`default_nettype none

// Hub control types, separate from the packet format
package hub_pkg;

    // Request side of one receiver
    typedef enum logic {
        RX_IDLE    = 1'b0,
        RX_PENDING = 1'b1
    } rx_state_e;

    // Field select of the read port
    typedef enum logic [2:0] {
        FLD_QW = 3'd0,
        FLD_QX = 3'd1,
        FLD_QY = 3'd2,
        FLD_QZ = 3'd3,
        FLD_GX = 3'd4,
        FLD_GY = 3'd5,
        FLD_GZ = 3'd6
    } field_e;

endpackage

`default_nettype wire

// File: src/hub_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// ==================================================
// Receiver to arbiter request bus
// ==================================================
// req rises with stable hdr_ok and rec, drops on the edge after gnt
interface sample_req_if import imu_pkg::*; ();
    logic     req;
    logic     gnt;
    logic     hdr_ok;
    imu_rec_t rec;

    modport src (output req, output hdr_ok, output rec, input gnt);
    modport arb (input req, input hdr_ok, input rec, output gnt);
endinterface

// ==================================================
// Arbiter to store write bus
// ==================================================
// we is a one-cycle strobe, payload valid with it
interface store_wr_if import imu_pkg::*; #(
    parameter int NUM_SENSORS = 2
) ();
    localparam int IDX_W = $clog2(NUM_SENSORS);

    logic             we;
    logic [IDX_W-1:0] sensor;
    logic             hdr_ok;
    imu_rec_t         rec;

    modport arb (output we, output sensor, output hdr_ok, output rec);
    modport store (input we, input sensor, input hdr_ok, input rec);
endinterface

`default_nettype wire

// File: src/spi_packet_rx.sv
`timescale 1ns/1ps
`default_nettype none

// SPI mode 0 packet receiver for one microcontroller
// Bytes shift in on sck and the packet moves to clk when ss_n rises
module spi_packet_rx import imu_pkg::*, hub_pkg::*; (
    input  logic      clk,
    input  logic      cs_n,
    input  logic      sck,
    input  logic      sdi,
    input  logic      ss_n,
    sample_req_if.src bus
);

    localparam int BYTE_W = $clog2(PACKET_BYTES);

    // ==================================================
    // sck domain
    // ==================================================
    logic [6:0]        shift_q;
    logic [2:0]        bit_cnt;
    logic [BYTE_W-1:0] byte_cnt;
    logic [7:0]        pkt_buf [PACKET_BYTES];

    // Counters restart whenever the master releases ss_n
    always_ff @(posedge sck or posedge ss_n) begin
        if (ss_n) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 3'd1;
            // 8th edge closes the byte
            if (bit_cnt == 3'd7) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // MSB first so shift left and append sdi
    always_ff @(posedge sck) begin
        shift_q <= {shift_q[5:0], sdi};
        if (!ss_n && bit_cnt == 3'd7) begin
            pkt_buf[byte_cnt] <= {shift_q, sdi};
        end
    end

    // ==================================================
    // clk domain
    // ==================================================
    logic      ss_meta;
    logic      ss_sync;
    logic      ss_prev;
    logic      ss_rise;
    rx_state_e state;
    imu_rec_t  dec;

    // End of transfer seen after the two-flop synchronizer
    assign ss_rise = ss_sync & ~ss_prev;

    // Buffer is quiet once ss_n is high so clk may sample it
    always_comb begin
        dec.quat_w     = {pkt_buf[1], pkt_buf[2]};
        dec.quat_x     = {pkt_buf[3], pkt_buf[4]};
        dec.quat_y     = {pkt_buf[5], pkt_buf[6]};
        dec.quat_z     = {pkt_buf[7], pkt_buf[8]};
        dec.gyro_x     = {pkt_buf[9], pkt_buf[10]};
        dec.gyro_y     = {pkt_buf[11], pkt_buf[12]};
        dec.gyro_z     = {pkt_buf[13], pkt_buf[14]};
        // Flag byte is the last one
        dec.quat_valid = pkt_buf[15][FLAG_QUAT_BIT];
        dec.gyro_valid = pkt_buf[15][FLAG_GYRO_BIT];
    end

    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            // Idle level of ss_n so no false edge out of reset
            ss_meta <= 1'b1;
            ss_sync <= 1'b1;
            ss_prev <= 1'b1;
            state   <= RX_IDLE;
            bus.req <= 1'b0;
        end else begin
            ss_meta <= ss_n;
            ss_sync <= ss_meta;
            ss_prev <= ss_sync;
            case (state)
                RX_IDLE: begin
                    if (ss_rise) begin
                        state   <= RX_PENDING;
                        bus.req <= 1'b1;
                    end
                end
                RX_PENDING: begin
                    // Write happens in the gnt cycle and req drops after it
                    if (bus.gnt) begin
                        state   <= RX_IDLE;
                        bus.req <= 1'b0;
                    end
                end
                default: begin
                    state   <= RX_IDLE;
                    bus.req <= 1'b0;
                end
            endcase
        end
    end

    // Snapshot only while idle
    // A packet ending in PENDING is dropped
    always_ff @(posedge clk) begin
        if (ss_rise && state == RX_IDLE) begin
            bus.hdr_ok <= (pkt_buf[0] == HEADER_BYTE);
            bus.rec    <= dec;
        end
    end

    // Snapshot stays put while req waits for gnt
    a_snap_stable: assert property (
        @(posedge clk) disable iff (cs_n)
        (bus.req && !bus.gnt) |=> ($stable(bus.rec) && $stable(bus.hdr_ok))
    );

endmodule

`default_nettype wire

// File: src/sample_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

// Round-robin arbiter, one receiver writes the store at a time
module sample_arbiter import imu_pkg::*; #(
    parameter int NUM_SENSORS = 2
) (
    input  logic      clk,
    input  logic      cs_n,
    sample_req_if.arb reqs [NUM_SENSORS],
    store_wr_if.arb   wr
);

    localparam int IDX_W = $clog2(NUM_SENSORS);

    logic [NUM_SENSORS-1:0] req_vec;
    logic [NUM_SENSORS-1:0] hdr_vec;
    imu_rec_t               rec_arr [NUM_SENSORS];
    logic [NUM_SENSORS-1:0] gnt_q;
    logic [NUM_SENSORS-1:0] gnt_nxt;
    logic [NUM_SENSORS-1:0] eligible;
    logic [IDX_W-1:0]       last_q;
    logic [IDX_W-1:0]       pick;

    // Interface arrays need constant indices
    for (genvar i = 0; i < NUM_SENSORS; i++) begin : g_port
        assign req_vec[i]  = reqs[i].req;
        assign hdr_vec[i]  = reqs[i].hdr_ok;
        assign rec_arr[i]  = reqs[i].rec;
        assign reqs[i].gnt = gnt_q[i];
    end

    // A receiver holding gnt still shows req this cycle, skip it
    assign eligible = req_vec & ~gnt_q;

    // Search starts one past the last winner
    always_comb begin
        int   idx;
        logic found;
        gnt_nxt = '0;
        pick    = last_q;
        found   = 1'b0;
        for (int k = 1; k <= NUM_SENSORS; k++) begin
            idx = (int'(last_q) + k) % NUM_SENSORS;
            if (!found && eligible[idx]) begin
                found        = 1'b1;
                pick         = IDX_W'(idx);
                gnt_nxt[idx] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            gnt_q  <= '0;
            // Sensor 0 wins first
            last_q <= IDX_W'(NUM_SENSORS - 1);
            wr.we  <= 1'b0;
        end else begin
            gnt_q <= gnt_nxt;
            if (|gnt_nxt) begin
                last_q <= pick;
            end
            wr.we <= |gnt_q;
        end
    end

    // last_q names the current grant holder during its gnt cycle
    always_ff @(posedge clk) begin
        if (|gnt_q) begin
            wr.sensor <= last_q;
            wr.hdr_ok <= hdr_vec[last_q];
            wr.rec    <= rec_arr[last_q];
        end
    end

    a_gnt_onehot: assert property (
        @(posedge clk) disable iff (cs_n) $onehot0(gnt_q)
    );

    // Grant must land on a receiver that still asks
    a_gnt_has_req: assert property (
        @(posedge clk) disable iff (cs_n) (gnt_q & ~req_vec) == '0
    );

endmodule

`default_nettype wire

// File: src/sample_store.sv
`timescale 1ns/1ps
`default_nettype none

// Latest record and status per sensor, registered read port
module sample_store import imu_pkg::*, hub_pkg::*; #(
    parameter int NUM_SENSORS = 2
) (
    input  logic                           clk,
    input  logic                           cs_n,
    input  logic [$clog2(NUM_SENSORS)-1:0] rd_sensor,
    input  field_e                         rd_field,
    store_wr_if.store                      wr,
    output logic signed [15:0]             rd_data,
    output logic [NUM_SENSORS-1:0]         initialized,
    output logic [NUM_SENSORS-1:0]         error,
    output logic [NUM_SENSORS-1:0]         quat_valid,
    output logic [NUM_SENSORS-1:0]         gyro_valid,
    output logic [NUM_SENSORS-1:0]         sample_upd
);

    imu_rec_t           recs [NUM_SENSORS];
    imu_rec_t           sel;
    logic signed [15:0] rd_nxt;

    // ==================================================
    // Write side
    // ==================================================
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            recs        <= '{default: '0};
            initialized <= '0;
            error       <= '0;
            sample_upd  <= '0;
        end else begin
            sample_upd <= '0;
            if (wr.we) begin
                // Pulse on every write, good or bad
                sample_upd[wr.sensor] <= 1'b1;
                if (wr.hdr_ok) begin
                    initialized[wr.sensor] <= 1'b1;
                    error[wr.sensor]       <= 1'b0;
                    recs[wr.sensor]        <= wr.rec;
                end else begin
                    // Bad header keeps the last good record
                    initialized[wr.sensor] <= 1'b0;
                    error[wr.sensor]       <= 1'b1;
                end
            end
        end
    end

    // Valid bits ride in the stored record
    for (genvar i = 0; i < NUM_SENSORS; i++) begin : g_valid
        assign quat_valid[i] = recs[i].quat_valid;
        assign gyro_valid[i] = recs[i].gyro_valid;
    end

    // ==================================================
    // Read side
    // ==================================================
    // Unused sensor codes read as zero
    assign sel = (int'(rd_sensor) < NUM_SENSORS) ? recs[rd_sensor] : '0;

    always_comb begin
        case (rd_field)
            FLD_QW:  rd_nxt = sel.quat_w;
            FLD_QX:  rd_nxt = sel.quat_x;
            FLD_QY:  rd_nxt = sel.quat_y;
            FLD_QZ:  rd_nxt = sel.quat_z;
            FLD_GX:  rd_nxt = sel.gyro_x;
            FLD_GY:  rd_nxt = sel.gyro_y;
            FLD_GZ:  rd_nxt = sel.gyro_z;
            default: rd_nxt = '0;
        endcase
    end

    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            rd_data <= '0;
        end else begin
            rd_data <= rd_nxt;
        end
    end

    // Arbiter must only forward real receivers
    a_wr_in_range: assert property (
        @(posedge clk) disable iff (cs_n) wr.we |-> (int'(wr.sensor) < NUM_SENSORS)
    );

endmodule

`default_nettype wire

// File: src/imu_spi_hub.sv
`timescale 1ns/1ps
`default_nettype none

// Two-port IMU sensor hub, SPI receive only
// One receiver per SPI port, shared store behind the arbiter
module imu_spi_hub import hub_pkg::*; #(
    parameter int NUM_SENSORS = 2
) (
    input  logic                           clk,
    input  logic                           cs_n,
    input  logic                           sck0,
    input  logic                           sdi0,
    input  logic                           ss0_n,
    input  logic                           sck1,
    input  logic                           sdi1,
    input  logic                           ss1_n,
    input  logic [$clog2(NUM_SENSORS)-1:0] rd_sensor,
    input  field_e                         rd_field,
    output logic signed [15:0]             rd_data,
    output logic [NUM_SENSORS-1:0]         initialized,
    output logic [NUM_SENSORS-1:0]         error,
    output logic [NUM_SENSORS-1:0]         quat_valid,
    output logic [NUM_SENSORS-1:0]         gyro_valid,
    output logic [NUM_SENSORS-1:0]         sample_upd
);

    // ==================================================
    // Internal buses
    // ==================================================
    sample_req_if                             req_bus [NUM_SENSORS] ();
    store_wr_if #(.NUM_SENSORS(NUM_SENSORS)) wr_bus ();

    // Port 0 receiver
    spi_packet_rx u_rx0 (
        .clk  (clk),
        .cs_n (cs_n),
        .sck  (sck0),
        .sdi  (sdi0),
        .ss_n (ss0_n),
        .bus  (req_bus[0])
    );

    // Port 1 receiver
    spi_packet_rx u_rx1 (
        .clk  (clk),
        .cs_n (cs_n),
        .sck  (sck1),
        .sdi  (sdi1),
        .ss_n (ss1_n),
        .bus  (req_bus[1])
    );

    sample_arbiter #(.NUM_SENSORS(NUM_SENSORS)) u_arb (
        .clk  (clk),
        .cs_n (cs_n),
        .reqs (req_bus),
        .wr   (wr_bus)
    );

    sample_store #(.NUM_SENSORS(NUM_SENSORS)) u_store (
        .clk         (clk),
        .cs_n        (cs_n),
        .rd_sensor   (rd_sensor),
        .rd_field    (rd_field),
        .wr          (wr_bus),
        .rd_data     (rd_data),
        .initialized (initialized),
        .error       (error),
        .quat_valid  (quat_valid),
        .gyro_valid  (gyro_valid),
        .sample_upd  (sample_upd)
    );

endmodule

`default_nettype wire

// File: verif/tb_imu_spi_hub.sv
`timescale 1ns/1ps
`default_nettype none

module tb_imu_spi_hub import imu_pkg::*, hub_pkg::*; ();

    localparam int NUM_SENSORS = 2;
    localparam int IDX_W       = $clog2(NUM_SENSORS);
    localparam int SCK_HALF    = 4;
    localparam int UPD_TIMEOUT = 200;
    localparam int SETTLE      = 12;

    // Byte 0 sits in the top byte so the wire order is MSB first overall
    typedef logic [PACKET_BYTES*8-1:0] pkt_bits_t;

    logic                   clk;
    logic                   cs_n;
    logic                   sck0;
    logic                   sdi0;
    logic                   ss0_n;
    logic                   sck1;
    logic                   sdi1;
    logic                   ss1_n;
    logic [IDX_W-1:0]       rd_sensor;
    field_e                 rd_field;
    logic signed [15:0]     rd_data;
    logic [NUM_SENSORS-1:0] initialized;
    logic [NUM_SENSORS-1:0] error;
    logic [NUM_SENSORS-1:0] quat_valid;
    logic [NUM_SENSORS-1:0] gyro_valid;
    logic [NUM_SENSORS-1:0] sample_upd;

    // Reference model state
    imu_rec_t               exp_rec [NUM_SENSORS];
    logic [NUM_SENSORS-1:0] exp_init;
    logic [NUM_SENSORS-1:0] exp_err;
    int                     exp_upd [NUM_SENSORS];
    int                     upd_cnt [NUM_SENSORS] = '{default: 0};

    int   check_cnt;
    int   err_cnt;
    int   test_cnt;
    logic aborted;

    imu_spi_hub #(.NUM_SENSORS(NUM_SENSORS)) dut0 (
        .clk(clk), .cs_n(cs_n),
        .sck0(sck0), .sdi0(sdi0), .ss0_n(ss0_n),
        .sck1(sck1), .sdi1(sdi1), .ss1_n(ss1_n),
        .rd_sensor(rd_sensor), .rd_field(rd_field), .rd_data(rd_data),
        .initialized(initialized), .error(error), .quat_valid(quat_valid),
        .gyro_valid(gyro_valid), .sample_upd(sample_upd)
    );

    always #4 clk = ~clk;

    // Count every update pulse per sensor
    always @(posedge clk) begin
        for (int s = 0; s < NUM_SENSORS; s++) begin
            if (sample_upd[s] === 1'b1) begin
                upd_cnt[s] <= upd_cnt[s] + 1;
            end
        end
    end

    // ==================================================
    // Packet helpers and reference model
    // ==================================================
    function automatic logic [7:0] pkt_byte(input pkt_bits_t p, input int idx);
        return p[(PACKET_BYTES-1-idx)*8 +: 8];
    endfunction

    // Word n is bytes 2n+1 (MSB) and 2n+2 (LSB)
    function automatic logic signed [15:0] pkt_word(input pkt_bits_t p, input int n);
        return {pkt_byte(p, 2*n+1), pkt_byte(p, 2*n+2)};
    endfunction

    function automatic imu_rec_t decode_packet(input pkt_bits_t p);
        imu_rec_t   r;
        logic [7:0] flags;
        r.quat_w       = pkt_word(p, 0);
        r.quat_x       = pkt_word(p, 1);
        r.quat_y       = pkt_word(p, 2);
        r.quat_z       = pkt_word(p, 3);
        r.gyro_x       = pkt_word(p, 4);
        r.gyro_y       = pkt_word(p, 5);
        r.gyro_z       = pkt_word(p, 6);
        flags          = pkt_byte(p, PACKET_BYTES-1);
        r.quat_valid   = flags[FLAG_QUAT_BIT];
        r.gyro_valid   = flags[FLAG_GYRO_BIT];
        return r;
    endfunction

    function automatic logic signed [15:0] exp_field(input imu_rec_t r, input field_e f);
        case (f)
            FLD_QW:  return r.quat_w;
            FLD_QX:  return r.quat_x;
            FLD_QY:  return r.quat_y;
            FLD_QZ:  return r.quat_z;
            FLD_GX:  return r.gyro_x;
            FLD_GY:  return r.gyro_y;
            FLD_GZ:  return r.gyro_z;
            default: return 16'sd0;
        endcase
    endfunction

    // Random body with the header forced good or forced bad
    function automatic pkt_bits_t random_packet(input logic bad_hdr);
        pkt_bits_t  p;
        logic [7:0] hdr;
        for (int k = 0; k < PACKET_BYTES; k++) begin
            p[k*8 +: 8] = 8'($urandom);
        end
        hdr = HEADER_BYTE;
        if (bad_hdr) begin
            hdr = 8'($urandom);
            if (hdr == HEADER_BYTE) begin
                hdr = ~HEADER_BYTE;
            end
        end
        p[PACKET_BYTES*8-1 -: 8] = hdr;
        return p;
    endfunction

    // Good header updates everything while a bad one keeps the old record
    task automatic apply_model(input int s, input pkt_bits_t p);
        exp_upd[s]++;
        if (pkt_byte(p, 0) == HEADER_BYTE) begin
            exp_init[s] = 1'b1;
            exp_err[s]  = 1'b0;
            exp_rec[s]  = decode_packet(p);
        end else begin
            exp_init[s] = 1'b0;
            exp_err[s]  = 1'b1;
        end
    endtask

    // ==================================================
    // SPI master driver
    // ==================================================
    task automatic drive_pins(input int s, input logic sck_v, input logic sdi_v,
                              input logic ss_v);
        @(posedge clk);
        #1;
        if (s == 0) begin
            sck0  = sck_v;
            sdi0  = sdi_v;
            ss0_n = ss_v;
        end else begin
            sck1  = sck_v;
            sdi1  = sdi_v;
            ss1_n = ss_v;
        end
    endtask

    // Mode 0 master with sdi changing while sck is low
    // Slave samples on the rising sck edge
    task automatic send_packet(input int s, input pkt_bits_t p);
        drive_pins(s, 1'b0, 1'b0, 1'b0);
        repeat (SCK_HALF) @(posedge clk);
        for (int b = PACKET_BYTES*8-1; b >= 0; b--) begin
            drive_pins(s, 1'b0, p[b], 1'b0);
            repeat (SCK_HALF-1) @(posedge clk);
            drive_pins(s, 1'b1, p[b], 1'b0);
            repeat (SCK_HALF-1) @(posedge clk);
        end
        drive_pins(s, 1'b0, 1'b0, 1'b0);
        repeat (SCK_HALF) @(posedge clk);
        drive_pins(s, 1'b0, 1'b0, 1'b1);
    endtask

    // ==================================================
    // Waits and compares
    // ==================================================
    task automatic wait_update(input int s);
        int cycles;
        cycles = 0;
        while (upd_cnt[s] < exp_upd[s] && cycles < UPD_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (upd_cnt[s] < exp_upd[s]) begin
            $display("Timeout: sensor %0d gave no sample_upd within %0d cycles",
                     s, UPD_TIMEOUT);
            aborted = 1'b1;
        end
    endtask

    task automatic check_word(input string name, input logic signed [15:0] got,
                              input logic signed [15:0] exp);
        check_cnt++;
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    // Extra pulses would show up during the settle window
    task automatic check_pulses(input int s);
        repeat (SETTLE) @(posedge clk);
        #1;
        check_cnt++;
        if (upd_cnt[s] != exp_upd[s]) begin
            $display("Sensor %0d gave %0d update pulses where %0d were due",
                     s, upd_cnt[s], exp_upd[s]);
            err_cnt++;
        end
    endtask

    // Read port answers one cycle after the select
    task automatic read_field(input int s, input field_e f, output logic signed [15:0] got);
        @(posedge clk);
        #1;
        rd_sensor = IDX_W'(s);
        rd_field  = f;
        @(posedge clk);
        #1;
        got = rd_data;
    endtask

    task automatic check_sensor(input int s);
        logic signed [15:0] got;
        field_e             f;
        check_bit($sformatf("initialized[%0d]", s), initialized[s], exp_init[s]);
        check_bit($sformatf("error[%0d]", s), error[s], exp_err[s]);
        check_bit($sformatf("quat_valid[%0d]", s), quat_valid[s], exp_rec[s].quat_valid);
        check_bit($sformatf("gyro_valid[%0d]", s), gyro_valid[s], exp_rec[s].gyro_valid);
        for (int fi = 0; fi < 7; fi++) begin
            f = field_e'(fi);
            read_field(s, f, got);
            check_word($sformatf("rd_data s%0d %s", s, f.name()), got, exp_field(exp_rec[s], f));
        end
    endtask

    // One packet end to end on one sensor
    task automatic packet_roundtrip(input int s, input pkt_bits_t p);
        send_packet(s, p);
        apply_model(s, p);
        wait_update(s);
        check_pulses(s);
        check_sensor(0);
        check_sensor(1);
    endtask

    task automatic report_test(input string name, input int err_before);
        test_cnt++;
        if (err_cnt == err_before && !aborted) begin
            $display("Test %0d %s: ok", test_cnt, name);
        end else begin
            $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - err_before);
        end
    endtask

    // ==================================================
    // Tests
    // ==================================================
    task automatic after_reset_values();
        int e0;
        e0 = err_cnt;
        for (int s = 0; s < NUM_SENSORS; s++) begin
            check_bit($sformatf("sample_upd[%0d]", s), sample_upd[s], 1'b0);
        end
        check_word("rd_data", rd_data, 16'sd0);
        check_sensor(0);
        check_sensor(1);
        report_test("after reset", e0);
    endtask

    task automatic valid_packet_s0();
        int e0;
        e0 = err_cnt;
        // Flag 0x01 marks quat valid and gyro not
        packet_roundtrip(0, {HEADER_BYTE, 16'h4000, 16'h0123, 16'hFEDC, 16'h8001,
                             16'h0010, 16'hFFF0, 16'h7FFF, 8'h01});
        report_test("valid packet on sensor 0", e0);
    endtask

    task automatic bad_header_s1();
        int e0;
        e0 = err_cnt;
        // Good packet first so the bad one has a record and flags to keep
        packet_roundtrip(1, {HEADER_BYTE, 16'h0C01, 16'hF3C2, 16'h0C03, 16'hF3C4,
                             16'h0C05, 16'hF3C6, 16'h0C07, 8'h02});
        packet_roundtrip(1, {8'h55, 16'h1111, 16'h2222, 16'h3333, 16'h4444,
                             16'h5555, 16'h6666, 16'h7777, 8'h03});
        report_test("bad header on sensor 1", e0);
    endtask

    task automatic simultaneous_ends();
        int        e0;
        pkt_bits_t pa;
        pkt_bits_t pb;
        e0 = err_cnt;
        pa = {HEADER_BYTE, 16'hA001, 16'hA002, 16'hA003, 16'hA004,
              16'h0A05, 16'h0A06, 16'h0A07, 8'h02};
        pb = {HEADER_BYTE, 16'hB001, 16'h0B02, 16'hB003, 16'h0B04,
              16'hB005, 16'h0B06, 16'hB007, 8'h03};
        // Same timing on both ports makes both ss_n rise together
        fork
            send_packet(0, pa);
            send_packet(1, pb);
        join
        apply_model(0, pa);
        apply_model(1, pb);
        wait_update(0);
        wait_update(1);
        check_pulses(0);
        check_pulses(1);
        check_sensor(0);
        check_sensor(1);
        report_test("both ss_n rise together", e0);
    endtask

    task automatic random_traffic();
        int   e0;
        int   s;
        logic bad;
        e0 = err_cnt;
        for (int n = 0; n < 20 && !aborted; n++) begin
            s   = int'($urandom % NUM_SENSORS);
            // About one header in eight corrupted
            bad = (($urandom % 8) == 0);
            packet_roundtrip(s, random_packet(bad));
        end
        report_test("random packets", e0);
    endtask

    initial begin
        void'($urandom(32'h4376_bb4a));
        clk       = 1'b0;
        cs_n      = 1'b1;
        sck0      = 1'b0;
        sdi0      = 1'b0;
        ss0_n     = 1'b1;
        sck1      = 1'b0;
        sdi1      = 1'b0;
        ss1_n     = 1'b1;
        rd_sensor = '0;
        rd_field  = FLD_QW;
        exp_rec   = '{default: '0};
        exp_init  = '0;
        exp_err   = '0;
        exp_upd   = '{default: 0};
        check_cnt = 0;
        err_cnt   = 0;
        test_cnt  = 0;
        aborted   = 1'b0;

        repeat (8) @(posedge clk);
        #1;
        cs_n = 1'b0;
        @(posedge clk);
        #1;

        after_reset_values();
        if (!aborted) valid_packet_s0();
        if (!aborted) bad_header_s1();
        if (!aborted) simultaneous_ends();
        if (!aborted) random_traffic();

        $display("Summary: %0d tests, %0d checks, %0d errors, %0d timeouts",
                 test_cnt, check_cnt, err_cnt, aborted ? 1 : 0);
        if (err_cnt == 0 && !aborted) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: imu_spi_hub.f
src/imu_pkg.sv
src/hub_pkg.sv
src/hub_ifs.sv
src/spi_packet_rx.sv
src/sample_arbiter.sv
src/sample_store.sv
src/imu_spi_hub.sv
verif/tb_imu_spi_hub.sv

// File: Makefile
# Verilator build and run of the IMU SPI hub testbench

TOP := tb_imu_spi_hub

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f imu_spi_hub.f -Mdir obj_dir -o $(TOP)

# Status comes from the search for the pass line
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^\*\*\* PASSED \*\*\*$$'

clean:
	rm -rf obj_dir
